//--- include/cpu_defs_defs.svh
/*
 * Core-wide constants for the 8-bit controller.
 * Special register addresses are the 8051 direct addresses. They are decoded
 * inside the core and never reach the external bus.
 * CPU_IDLE_CYCLES sets the idle wait length. The wait lasts one cycle more
 * than this value.
 */
`ifndef CPU_DEFS_DEFS_SVH
`define CPU_DEFS_DEFS_SVH

// ----------------------------------------------------------------------------
// widths
// ----------------------------------------------------------------------------
`define CPU_DATA_W 8
`define CPU_ADDR_W 16

// idle wait after reset and after NOP
`define CPU_IDLE_CYCLES 6

// ----------------------------------------------------------------------------
// internal registers in direct address space
// ----------------------------------------------------------------------------
`define CPU_SFR_ACC 8'hE0
`define CPU_SFR_B   8'hF0
`define CPU_SFR_PSW 8'hD0

`endif

//--- hw/cpu_pkg.sv
/*
 * Shared types for the controller core.
 * The state encoding is one-hot. Unsupported opcodes are not listed here
 * and are treated as NOP by the decoder.
 */
`include "cpu_defs_defs.svh"

package cpu_pkg;

    typedef enum logic [6:0] {
        ST_IDLE      = 7'b000_0001,
        ST_FETCH     = 7'b000_0010,
        ST_DECODE    = 7'b000_0100,
        ST_RAM_READ  = 7'b000_1000,
        ST_ROM_READ  = 7'b001_0000,
        ST_PROCESS   = 7'b010_0000,
        ST_RAM_WRITE = 7'b100_0000
    } cpu_state_e;

    typedef enum logic [7:0] {
        OPC_NOP         = 8'h00,
        OPC_LJMP        = 8'h02,
        OPC_INC_A       = 8'h04,
        OPC_ADD_IMM     = 8'h24,
        OPC_ADD_DIR     = 8'h25,
        OPC_ORL_IMM     = 8'h44,
        OPC_ANL_IMM     = 8'h54,
        OPC_XRL_IMM     = 8'h64,
        OPC_MOV_A_IMM   = 8'h74,
        OPC_MOV_DIR_DIR = 8'h85,
        OPC_MOV_A_DIR   = 8'hE5,
        OPC_MOV_DIR_A   = 8'hF5
    } opcode_e;

    // state entered after decode
    typedef enum logic [2:0] {
        K_ROM_READ, K_RAM_READ, K_PROCESS, K_RAM_WRITE, K_IDLE, K_FETCH
    } step_kind_e;

    typedef enum logic [2:0] {
        OPD_ACC, OPD_RAM_DATA, OPD_ROM_DATA, OPD_PCH, OPD_PCL, OPD_NONE
    } operand_e;

    typedef enum logic [2:0] {
        ALU_PASS, ALU_ADD, ALU_INC, ALU_AND, ALU_OR, ALU_XOR
    } alu_op_e;

    typedef struct packed {
        logic       cy;
        logic       ac;
        logic       f0;
        logic [1:0] rs;
        logic       ov;
        logic       f1;
        logic       p;   // parity of ACC
    } psw_t;

    typedef struct packed {
        logic [`CPU_ADDR_W-1:0] addr;
        logic                   rd_en;
        logic                   wr_en;
        logic                   ram_sel; // 1 = RAM, 0 = ROM
        logic [`CPU_DATA_W-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        step_kind_e kind;
        operand_e   dst;       // ALU a operand and result target
        operand_e   src_b;     // ALU b operand, also RAM write data
        alu_op_e    op;
        operand_e   addr_from; // register holding the direct address
    } step_t;

endpackage

//--- hw/ins_decoder.sv
/*
 * Opcode and phase to step decoder, purely combinational.
 * run_phase of 0 means the instruction has just been fetched and is read
 * as the first step. Opcodes outside the subset decode as a one-step NOP.
 */
`timescale 1ns/1ps
`include "cpu_defs_defs.svh"

module ins_decoder
    import cpu_pkg::*;
(
    input  opcode_e    opcode,
    input  logic [3:0] run_phase,
    output step_t      step,
    output logic [3:0] phase_init
);

    logic [3:0] ph;
    logic [3:0] idx;    // 0 = first step
    alu_op_e    op_sel;

    function automatic step_t mk(step_kind_e k, operand_e d, operand_e s, alu_op_e o,
                                 operand_e a);
        return '{kind: k, dst: d, src_b: s, op: o, addr_from: a};
    endfunction

    // step count and ALU operation per opcode
    always_comb begin
        case (opcode)
            OPC_MOV_A_IMM, OPC_ADD_IMM, OPC_ANL_IMM,
            OPC_ORL_IMM, OPC_XRL_IMM, OPC_MOV_DIR_A: phase_init = 4'd2;
            OPC_MOV_A_DIR, OPC_ADD_DIR:              phase_init = 4'd3;
            OPC_MOV_DIR_DIR:                         phase_init = 4'd4;
            OPC_LJMP:                                phase_init = 4'd5;
            default:                                 phase_init = 4'd1; // NOP, INC A
        endcase
        case (opcode)
            OPC_ADD_IMM, OPC_ADD_DIR: op_sel = ALU_ADD;
            OPC_ANL_IMM:              op_sel = ALU_AND;
            OPC_ORL_IMM:              op_sel = ALU_OR;
            OPC_XRL_IMM:              op_sel = ALU_XOR;
            OPC_INC_A:                op_sel = ALU_INC;
            default:                  op_sel = ALU_PASS;
        endcase
    end

    assign ph  = (run_phase == 4'd0) ? phase_init : run_phase;
    assign idx = phase_init - ph;

    always_comb begin
        step = mk(K_FETCH, OPD_NONE, OPD_NONE, ALU_PASS, OPD_NONE); // past last step
        case (opcode)
            OPC_MOV_A_IMM, OPC_ADD_IMM, OPC_ANL_IMM, OPC_ORL_IMM, OPC_XRL_IMM: begin
                if (idx == 4'd0) step = mk(K_ROM_READ, OPD_NONE, OPD_NONE, ALU_PASS, OPD_NONE);
                else if (idx == 4'd1)
                    step = mk(K_PROCESS, OPD_ACC, OPD_ROM_DATA, op_sel, OPD_NONE);
            end
            OPC_MOV_A_DIR, OPC_ADD_DIR: begin
                case (idx)
                    4'd0: step = mk(K_ROM_READ, OPD_NONE, OPD_NONE, ALU_PASS, OPD_NONE);
                    4'd1: step = mk(K_RAM_READ, OPD_NONE, OPD_NONE, ALU_PASS, OPD_ROM_DATA);
                    4'd2: step = mk(K_PROCESS, OPD_ACC, OPD_RAM_DATA, op_sel, OPD_NONE);
                    default: ;
                endcase
            end
            OPC_MOV_DIR_A: begin
                if (idx == 4'd0) step = mk(K_ROM_READ, OPD_NONE, OPD_NONE, ALU_PASS, OPD_NONE);
                else if (idx == 4'd1)
                    step = mk(K_RAM_WRITE, OPD_NONE, OPD_ACC, ALU_PASS, OPD_ROM_DATA);
            end
            OPC_MOV_DIR_DIR: begin // source byte comes first in the code stream
                case (idx)
                    4'd0, 4'd2:
                        step = mk(K_ROM_READ, OPD_NONE, OPD_NONE, ALU_PASS, OPD_NONE);
                    4'd1: step = mk(K_RAM_READ, OPD_NONE, OPD_NONE, ALU_PASS, OPD_ROM_DATA);
                    4'd3: step = mk(K_RAM_WRITE, OPD_NONE, OPD_RAM_DATA, ALU_PASS, OPD_ROM_DATA);
                    default: ;
                endcase
            end
            OPC_INC_A: begin
                if (idx == 4'd0) step = mk(K_PROCESS, OPD_ACC, OPD_NONE, ALU_INC, OPD_NONE);
            end
            OPC_LJMP: begin
                // high byte parks in the RAM data register while the low byte is read
                case (idx)
                    4'd0, 4'd2:
                        step = mk(K_ROM_READ, OPD_NONE, OPD_NONE, ALU_PASS, OPD_NONE);
                    4'd1: step = mk(K_PROCESS, OPD_RAM_DATA, OPD_ROM_DATA, ALU_PASS, OPD_NONE);
                    4'd3: step = mk(K_PROCESS, OPD_PCL, OPD_ROM_DATA, ALU_PASS, OPD_NONE);
                    4'd4: step = mk(K_PROCESS, OPD_PCH, OPD_RAM_DATA, ALU_PASS, OPD_NONE);
                    default: ;
                endcase
            end
            default: begin
                if (idx == 4'd0) step = mk(K_IDLE, OPD_NONE, OPD_NONE, ALU_PASS, OPD_NONE);
            end
        endcase
    end

endmodule

//--- hw/alu.sv
/*
 * 8-bit ALU, combinational.
 * Only ADD touches the flags (cy, ac, ov). Parity is left to the caller,
 * which knows whether the result lands in ACC.
 */
`timescale 1ns/1ps
`include "cpu_defs_defs.svh"

module alu
    import cpu_pkg::*;
(
    input  alu_op_e                op,
    input  logic [`CPU_DATA_W-1:0] a,
    input  logic [`CPU_DATA_W-1:0] b,
    input  psw_t                   psw_in,
    output logic [`CPU_DATA_W-1:0] result,
    output psw_t                   psw_out
);

    logic [`CPU_DATA_W:0] sum;   // with carry out
    logic [4:0]           half;  // low nibble sum, bit 4 is aux carry

    assign sum  = {1'b0, a} + {1'b0, b};
    assign half = {1'b0, a[3:0]} + {1'b0, b[3:0]};

    always_comb begin
        psw_out = psw_in;
        case (op)
            ALU_ADD: begin
                result     = sum[`CPU_DATA_W-1:0];
                psw_out.cy = sum[`CPU_DATA_W];
                psw_out.ac = half[4];
                // same operand signs, different result sign
                psw_out.ov = (a[7] == b[7]) && (sum[7] != a[7]);
            end
            ALU_INC: result = a + 8'd1; // flags untouched
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            default: result = b;        // PASS
        endcase
    end

endmodule

//--- hw/cpu_control.sv
/*
 * Core sequencer: state machine, registers, program counter, bus driver.
 * Bus reads and writes are single-cycle strobes with no wait states. The
 * strobe is registered in the first cycle of a state and rdata is captured
 * at the end of the second. Direct addresses E0h, F0h and D0h are served
 * internally in one cycle without a strobe. ROM is never written.
 */
`timescale 1ns/1ps
`include "cpu_defs_defs.svh"

module cpu_control
    import cpu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] rdata,
    input  step_t      step,
    input  logic [3:0] phase_init,
    output opcode_e    opcode,
    output logic [3:0] run_phase,
    output alu_op_e    alu_op,
    output logic [7:0] alu_a,
    output logic [7:0] alu_b,
    output psw_t       psw_cur,
    input  logic [7:0] alu_result,
    input  psw_t       psw_new,
    output mem_req_t   mem
);

    localparam int CNT_W = $clog2(`CPU_IDLE_CYCLES + 1);

    cpu_state_e state, state_nxt;
    logic       second, second_nxt;       // second cycle of a bus state
    logic [CNT_W-1:0] idle_cnt, idle_cnt_nxt;
    logic [3:0] phase, phase_nxt;
    logic [7:0] acc, acc_nxt, b_reg, b_nxt;
    psw_t       psw, psw_nxt;
    logic [15:0] pc, pc_nxt;
    mem_req_t   mem_q, mem_nxt;
    logic [7:0] ir, ir_nxt;               // instruction register
    logic [7:0] rom_q, rom_q_nxt, ram_q, ram_q_nxt;
    logic [7:0] ram_addr, sfr_val;
    logic       sfr_hit, step_done;

    function automatic logic [7:0] pick(operand_e sel, logic [7:0] acc_v, logic [7:0] ram_v,
                                        logic [7:0] rom_v, logic [15:0] pc_v);
        case (sel)
            OPD_ACC:      return acc_v;
            OPD_RAM_DATA: return ram_v;
            OPD_ROM_DATA: return rom_v;
            OPD_PCH:      return pc_v[15:8];
            OPD_PCL:      return pc_v[7:0];
            default:      return 8'h00;
        endcase
    endfunction

    assign opcode    = opcode_e'(ir);
    assign run_phase = phase;
    assign alu_op    = step.op;
    assign alu_a     = pick(step.dst, acc, ram_q, rom_q, pc);
    assign alu_b     = pick(step.src_b, acc, ram_q, rom_q, pc); // also write data
    assign ram_addr  = pick(step.addr_from, acc, ram_q, rom_q, pc);
    assign psw_cur   = psw;
    assign mem       = mem_q;

    always_comb begin
        sfr_hit = 1'b1;
        case (ram_addr)
            `CPU_SFR_ACC: sfr_val = acc;
            `CPU_SFR_B:   sfr_val = b_reg;
            `CPU_SFR_PSW: sfr_val = psw;
            default: begin
                sfr_hit = 1'b0;
                sfr_val = 8'h00;
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // next state
    // ------------------------------------------------------------------------
    always_comb begin
        state_nxt    = state;
        second_nxt   = 1'b0;
        idle_cnt_nxt = idle_cnt;
        phase_nxt    = phase;
        acc_nxt      = acc;
        b_nxt        = b_reg;
        psw_nxt      = psw;
        pc_nxt       = pc;
        ir_nxt       = ir;
        rom_q_nxt    = rom_q;
        ram_q_nxt    = ram_q;
        mem_nxt       = mem_q;
        mem_nxt.rd_en = 1'b0;      // strobes last one cycle
        mem_nxt.wr_en = 1'b0;
        step_done    = 1'b0;

        case (state)
            ST_IDLE: begin
                if (idle_cnt == '0) begin
                    state_nxt    = ST_FETCH;
                    idle_cnt_nxt = CNT_W'(`CPU_IDLE_CYCLES);
                end else begin
                    idle_cnt_nxt = idle_cnt - 1'b1;
                end
            end
            ST_FETCH: begin
                phase_nxt = 4'd0;
                if (second) begin
                    ir_nxt    = rdata;
                    pc_nxt    = pc + 16'd1;
                    state_nxt = ST_DECODE;
                end else begin
                    mem_nxt.addr    = pc;
                    mem_nxt.ram_sel = 1'b0;
                    mem_nxt.rd_en   = 1'b1;
                    second_nxt      = 1'b1;
                end
            end
            ST_DECODE: begin
                if (phase == 4'd0) phase_nxt = phase_init;
                case (step.kind)
                    K_ROM_READ:  state_nxt = ST_ROM_READ;
                    K_RAM_READ:  state_nxt = ST_RAM_READ;
                    K_PROCESS:   state_nxt = ST_PROCESS;
                    K_RAM_WRITE: state_nxt = ST_RAM_WRITE;
                    K_IDLE:      state_nxt = ST_IDLE;
                    default:     state_nxt = ST_FETCH;
                endcase
            end
            ST_ROM_READ: begin
                if (second) begin
                    rom_q_nxt = rdata;
                    pc_nxt    = pc + 16'd1;
                    step_done = 1'b1;
                end else begin
                    mem_nxt.addr    = pc;
                    mem_nxt.ram_sel = 1'b0;
                    mem_nxt.rd_en   = 1'b1;
                    second_nxt      = 1'b1;
                end
            end
            ST_RAM_READ: begin
                if (sfr_hit) begin
                    ram_q_nxt = sfr_val;
                    step_done = 1'b1;
                end else if (second) begin
                    ram_q_nxt = rdata;
                    step_done = 1'b1;
                end else begin
                    mem_nxt.addr    = {8'h00, ram_addr};
                    mem_nxt.ram_sel = 1'b1;
                    mem_nxt.rd_en   = 1'b1;
                    second_nxt      = 1'b1;
                end
            end
            ST_PROCESS: begin
                step_done = 1'b1;
                case (step.dst)
                    OPD_ACC: begin
                        acc_nxt   = alu_result;
                        psw_nxt   = psw_new;
                        psw_nxt.p = ^alu_result;
                    end
                    OPD_RAM_DATA: ram_q_nxt = alu_result;
                    OPD_ROM_DATA: rom_q_nxt = alu_result;
                    OPD_PCH:      pc_nxt[15:8] = alu_result;
                    OPD_PCL:      pc_nxt[7:0] = alu_result;
                    default: ;
                endcase
            end
            ST_RAM_WRITE: begin
                if (sfr_hit) begin
                    step_done = 1'b1;
                    case (ram_addr)
                        `CPU_SFR_ACC: begin
                            acc_nxt   = alu_b;
                            psw_nxt.p = ^alu_b;
                        end
                        `CPU_SFR_B: b_nxt   = alu_b;
                        default:    psw_nxt = psw_t'(alu_b);
                    endcase
                end else if (second) begin
                    step_done = 1'b1;
                end else begin
                    mem_nxt.addr    = {8'h00, ram_addr};
                    mem_nxt.ram_sel = 1'b1;
                    mem_nxt.wdata   = alu_b;
                    mem_nxt.wr_en   = 1'b1;
                    second_nxt      = 1'b1;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase

        // last phase ends the instruction
        if (step_done) begin
            phase_nxt = phase - 4'd1;
            state_nxt = (phase == 4'd1) ? ST_FETCH : ST_DECODE;
        end
    end

    // ------------------------------------------------------------------------
    // registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            second   <= 1'b0;
            idle_cnt <= CNT_W'(`CPU_IDLE_CYCLES);
            phase    <= 4'd0;
            acc      <= 8'h00;
            b_reg    <= 8'h00;
            psw      <= '0;
            pc       <= 16'h0000;
            mem_q    <= '0;
        end else begin
            state    <= state_nxt;
            second   <= second_nxt;
            idle_cnt <= idle_cnt_nxt;
            phase    <= phase_nxt;
            acc      <= acc_nxt;
            b_reg    <= b_nxt;
            psw      <= psw_nxt;
            pc       <= pc_nxt;
            mem_q    <= mem_nxt;
        end
    end

    always_ff @(posedge clk) begin
        ir    <= ir_nxt;
        rom_q <= rom_q_nxt;
        ram_q <= ram_q_nxt;
    end

endmodule

//--- hw/cpu_top.sv
/*
 * Controller core top level.
 * One external bus for ROM and RAM. rdata must be valid combinationally
 * while mem.rd_en is high, and there is no wait state.
 */
`timescale 1ns/1ps
`include "cpu_defs_defs.svh"

module cpu_top
    import cpu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`CPU_DATA_W-1:0] rdata,
    output mem_req_t               mem
);

    step_t      step;
    opcode_e    opcode;
    logic [3:0] run_phase, phase_init;
    alu_op_e    alu_op;
    logic [7:0] alu_a, alu_b, alu_result;
    psw_t       psw_cur, psw_new;

    ins_decoder dec_i (
        .opcode(opcode),
        .run_phase(run_phase),
        .step(step),
        .phase_init(phase_init)
    );

    alu alu_i (
        .op(alu_op),
        .a(alu_a),
        .b(alu_b),
        .psw_in(psw_cur),
        .result(alu_result),
        .psw_out(psw_new)
    );

    cpu_control ctrl_i (
        .clk(clk),
        .rst_n(rst_n),
        .rdata(rdata),
        .step(step),
        .phase_init(phase_init),
        .opcode(opcode),
        .run_phase(run_phase),
        .alu_op(alu_op),
        .alu_a(alu_a),
        .alu_b(alu_b),
        .psw_cur(psw_cur),
        .alu_result(alu_result),
        .psw_new(psw_new),
        .mem(mem)
    );

endmodule

//--- testbench/tb_mem.sv
/*
 * Behavioral ROM and RAM on the core bus, with no wait states.
 * Reads answer combinationally while rd_en is high. RAM writes land at the
 * rising edge. ROM is loaded by the testbench through the rom array.
 * A high fill at a rising edge rewrites all RAM with its start pattern.
 */
`timescale 1ns/1ps
`include "cpu_defs_defs.svh"

module tb_mem
    import cpu_pkg::*;
(
    input  logic                   clk,
    input  logic                   fill,
    input  mem_req_t               mem,
    output logic [`CPU_DATA_W-1:0] rdata
);

    logic [7:0] rom [0:65535];
    logic [7:0] ram [0:255];

    // start pattern, every address bit matters
    function automatic logic [7:0] ram_start(logic [7:0] a);
        return (a * 8'd29) ^ {a[3:0], a[7:4]} ^ 8'h5C;
    endfunction

    always @(posedge clk) begin
        if (fill) begin
            for (int i = 0; i < 256; i++) begin
                ram[i] <= ram_start(i[7:0]);
            end
        end else if (mem.wr_en && mem.ram_sel) begin
            ram[mem.addr[7:0]] <= mem.wdata;
        end
    end

    // ROM writes never happen on this bus
    assign rdata = !mem.rd_en  ? 8'h00 :
                   mem.ram_sel ? ram[mem.addr[7:0]] :
                                 rom[mem.addr];

endmodule

//--- testbench/tb_cpu.sv
/*
 * Testbench for the controller core.
 * Each test loads a ROM image under reset and runs an instruction-level
 * model over it. Every ROM read address and every RAM write on the bus is
 * then compared with the model. RAM read strobes are only checked by the
 * bus assertions, not by address.
 */
`timescale 1ns/1ps
`include "cpu_defs_defs.svh"

module tb_cpu
    import cpu_pkg::*;
();

    localparam int NUM_TESTS    = 5;
    localparam int PROG_INS     = 38;    // instructions over all programs
    localparam int WATCH_CYCLES = PROG_INS * 40 + NUM_TESTS * 40;
    // idle wait plus one edge to register the fetch strobe
    localparam int FIRST_FETCH  = `CPU_IDLE_CYCLES + 2;

    logic       clk;
    logic       rst_n;
    logic       fill;
    logic [7:0] rdata;
    mem_req_t   bus;

    int          errors;
    int          test_err0;
    int          tests_run;
    int          failed_tests;
    bit          active;
    bit          done_flag;
    logic [15:0] exp_rom [$];
    logic [7:0]  exp_waddr [$];
    logic [7:0]  exp_wdata [$];
    logic [15:0] wp;                     // ROM image write pointer
    logic [15:0] ea16;
    logic [7:0]  ea8;
    logic [7:0]  ed8;

    // model state
    logic [7:0]  m_acc;
    logic [7:0]  m_b;
    logic [7:0]  m_psw;                  // cy ac f0 rs1 rs0 ov f1 p
    logic [15:0] m_pc;
    logic [7:0]  m_ram [0:255];

    cpu_top dut_i (
        .clk(clk),
        .rst_n(rst_n),
        .rdata(rdata),
        .mem(bus)
    );

    tb_mem mem_i (
        .clk(clk),
        .fill(fill),
        .mem(bus),
        .rdata(rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(WATCH_CYCLES * 8);
        $display("%0t ns: watchdog expired, the core stopped making progress", $time);
        $display("Done: errors found");
        $finish;
    end

    // ------------------------------------------------------------------------
    // bus rules
    // ------------------------------------------------------------------------
    a_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(bus.rd_en && bus.wr_en))
        else note_fail("read and write strobes at once");
    a_rom_ro: assert property (@(posedge clk) disable iff (!rst_n)
        bus.wr_en |-> bus.ram_sel)
        else note_fail("write strobe aimed at ROM");
    a_ram_page: assert property (@(posedge clk) disable iff (!rst_n)
        (bus.ram_sel && (bus.rd_en || bus.wr_en)) |-> (bus.addr[15:8] == 8'h00))
        else note_fail("RAM address wider than 8 bits");
    a_sfr_inside: assert property (@(posedge clk) disable iff (!rst_n)
        (bus.ram_sel && (bus.rd_en || bus.wr_en)) |->
            !(bus.addr[7:0] inside {`CPU_SFR_ACC, `CPU_SFR_B, `CPU_SFR_PSW}))
        else note_fail("special register access reached the bus");
    a_rd_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        bus.rd_en |=> !bus.rd_en)
        else note_fail("read strobe longer than one cycle");
    a_wr_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        bus.wr_en |=> !bus.wr_en)
        else note_fail("write strobe longer than one cycle");

    task automatic note_fail(string msg);
        errors++;
        $display("%0t ns: %s", $time, msg);
    endtask

    task automatic note_mismatch(string sig, logic [15:0] exp_v, logic [15:0] act_v);
        errors++;
        $display("Mismatch at %0t ns: %s expected 0x%0h, actual 0x%0h",
                 $time, sig, exp_v, act_v);
    endtask

    function automatic logic [7:0] rand8();
        logic [31:0] r;
        r = $urandom();
        return r[7:0];
    endfunction

    // same start pattern as the memory model
    function automatic logic [7:0] ram_start(logic [7:0] a);
        return (a * 8'd29) ^ {a[3:0], a[7:4]} ^ 8'h5C;
    endfunction

    // ------------------------------------------------------------------------
    // instruction model
    // ------------------------------------------------------------------------
    function automatic logic [7:0] rom_byte();
        logic [7:0] v;
        v = mem_i.rom[m_pc];
        exp_rom.push_back(m_pc);   // every code byte is one ROM read
        m_pc = m_pc + 16'd1;
        return v;
    endfunction

    function automatic void set_acc(logic [7:0] v);
        m_acc    = v;
        m_psw[0] = ^v;
    endfunction

    // flags from the number ranges of the full sums
    function automatic void add_acc(logic [7:0] v);
        int u_sum;
        int s_sum;
        int n_sum;
        u_sum    = int'(m_acc) + int'(v);
        s_sum    = int'($signed(m_acc)) + int'($signed(v));
        n_sum    = int'(m_acc[3:0]) + int'(v[3:0]);
        m_psw[7] = (u_sum > 255);
        m_psw[6] = (n_sum > 15);
        m_psw[2] = (s_sum > 127) || (s_sum < -128);
        set_acc(u_sum[7:0]);
    endfunction

    function automatic logic [7:0] rd_dir(logic [7:0] a);
        case (a)
            `CPU_SFR_ACC: return m_acc;
            `CPU_SFR_B:   return m_b;
            `CPU_SFR_PSW: return m_psw;
            default:      return m_ram[a];
        endcase
    endfunction

    function automatic void wr_dir(logic [7:0] a, logic [7:0] v);
        case (a)
            `CPU_SFR_ACC: set_acc(v);
            `CPU_SFR_B:   m_b = v;
            `CPU_SFR_PSW: m_psw = v;   // parity bit taken as written
            default: begin
                exp_waddr.push_back(a);
                exp_wdata.push_back(v);
                m_ram[a] = v;
            end
        endcase
    endfunction

    task automatic run_model(int n);
        logic [7:0] opc;
        logic [7:0] b1;
        logic [7:0] b2;
        for (int i = 0; i < n; i++) begin
            opc = rom_byte();
            case (opc)
                8'h74: set_acc(rom_byte());
                8'hE5: set_acc(rd_dir(rom_byte()));
                8'hF5: wr_dir(rom_byte(), m_acc);
                8'h85: begin          // source first
                    b1 = rd_dir(rom_byte());
                    b2 = rom_byte();
                    wr_dir(b2, b1);
                end
                8'h24: add_acc(rom_byte());
                8'h25: add_acc(rd_dir(rom_byte()));
                8'h54: set_acc(m_acc & rom_byte());
                8'h44: set_acc(m_acc | rom_byte());
                8'h64: set_acc(m_acc ^ rom_byte());
                8'h04: set_acc(m_acc + 8'd1);
                8'h02: begin
                    b1   = rom_byte();
                    b2   = rom_byte();
                    m_pc = {b1, b2};
                end
                default: ;            // behaves as NOP
            endcase
        end
        exp_rom.push_back(m_pc);      // fetch that ends the last instruction
    endtask

    // ------------------------------------------------------------------------
    // bus monitor, sampled mid-cycle
    // ------------------------------------------------------------------------
    always @(negedge clk) begin
        if (active && bus.wr_en) begin
            assert (exp_waddr.size() != 0) else note_fail("unexpected RAM write");
            if (exp_waddr.size() != 0) begin
                ea8 = exp_waddr.pop_front();
                ed8 = exp_wdata.pop_front();
                assert (bus.addr[7:0] == ea8)
                    else note_mismatch("mem.addr (RAM write)", {8'h00, ea8}, bus.addr);
                assert (bus.wdata == ed8)
                    else note_mismatch("mem.wdata", {8'h00, ed8}, {8'h00, bus.wdata});
            end
        end
        if (active && bus.rd_en && !bus.ram_sel) begin
            ea16 = exp_rom.pop_front();
            assert (bus.addr == ea16) else note_mismatch("mem.addr (ROM read)", ea16, bus.addr);
            if (exp_rom.size() == 0) begin
                assert (exp_waddr.size() == 0) else note_fail("RAM writes missing");
                active    = 1'b0;
                done_flag = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // test sequencing
    // ------------------------------------------------------------------------
    task automatic begin_test();
        @(negedge clk);
        rst_n     = 1'b0;
        fill      = 1'b1;
        active    = 1'b0;
        test_err0 = errors;
        exp_rom.delete();
        exp_waddr.delete();
        exp_wdata.delete();
        for (int i = 0; i < 65536; i++) begin
            mem_i.rom[i] = 8'h00;
        end
        wp = 16'h0000;
        @(negedge clk);
        fill = 1'b0;
    endtask

    task automatic emit(logic [7:0] b);
        mem_i.rom[wp] = b;
        wp = wp + 16'd1;
    endtask

    task automatic report_test(string name);
        tests_run++;
        if (errors == test_err0) begin
            $display("test %-18s ok", name);
        end else begin
            failed_tests++;
            $display("test %-18s FAILED (%0d errors)", name, errors - test_err0);
        end
    endtask

    task automatic finish_test(string name, int n);
        m_acc = 8'h00;
        m_b   = 8'h00;
        m_psw = 8'h00;
        m_pc  = 16'h0000;
        for (int i = 0; i < 256; i++) begin
            m_ram[i] = ram_start(i[7:0]);
        end
        run_model(n);
        done_flag = 1'b0;
        active    = 1'b1;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        while (!done_flag) @(negedge clk);
        report_test(name);
    endtask

    task automatic test_reset();
        int edges;
        begin_test();
        assert (!bus.rd_en && !bus.wr_en) else note_fail("strobe active in reset");
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        edges = 0;
        while (!bus.rd_en && edges < 20) begin
            @(negedge clk);
            edges++;
            assert (!bus.wr_en) else note_fail("write strobe before first fetch");
        end
        assert (edges == FIRST_FETCH)
            else note_mismatch("first fetch edge", FIRST_FETCH[15:0], edges[15:0]);
        assert (bus.addr == 16'h0000 && !bus.ram_sel)
            else note_mismatch("mem.addr (first fetch)", 16'h0000, bus.addr);
        report_test("reset");
    endtask

    task automatic test_moves();
        begin_test();
        emit(8'h74); emit(rand8());
        emit(8'hF5); emit(8'h30);
        emit(8'hE5); emit(8'h40);
        emit(8'hF5); emit(8'h31);
        emit(8'h85); emit(8'h41); emit(8'h32);
        emit(8'h25); emit(8'h42);
        emit(8'hF5); emit(8'h33);
        emit(8'h85); emit(`CPU_SFR_ACC); emit(8'h34);
        emit(8'hF5); emit(`CPU_SFR_B);
        emit(8'h85); emit(`CPU_SFR_B); emit(8'h35);
        finish_test("data moves", 10);
    endtask

    task automatic test_add_flags();
        logic [7:0] a_v [4] = '{8'hFF, 8'h7F, 8'h80, 8'h0F};
        logic [7:0] b_v [4] = '{8'h01, 8'h01, 8'h80, 8'h01};
        begin_test();
        for (int k = 0; k < 4; k++) begin
            emit(8'h74); emit(a_v[k]);
            emit(8'h24); emit(b_v[k]);
            emit(8'h85); emit(`CPU_SFR_PSW); emit(8'h50 + k[7:0]);
        end
        finish_test("add flags", 12);
    endtask

    task automatic test_logic();
        begin_test();
        emit(8'h74); emit(rand8() | 8'h11);
        emit(8'h24); emit(8'hFF);         // leaves cy and ac set
        emit(8'h54); emit(rand8());
        emit(8'hF5); emit(8'h60);
        emit(8'h44); emit(rand8());
        emit(8'hF5); emit(8'h61);
        emit(8'h64); emit(rand8());
        emit(8'hF5); emit(8'h62);
        emit(8'h04);
        emit(8'hF5); emit(8'h63);
        emit(8'h85); emit(`CPU_SFR_PSW); emit(8'h64);
        finish_test("logic and inc", 11);
    endtask

    task automatic test_jump();
        logic [7:0] hi;
        logic [7:0] lo;
        hi = 8'h10 + (rand8() & 8'h7F);   // well clear of the start code
        lo = rand8();
        begin_test();
        emit(8'h74); emit(rand8());
        emit(8'h13);                      // unsupported opcode
        emit(8'h02); emit(hi); emit(lo);
        wp = {hi, lo};
        emit(8'hA5);                      // unsupported opcode
        emit(8'hF5); emit(8'h20);
        finish_test("jump and unknown", 5);
    endtask

    initial begin
        void'($urandom(32'h7865c803));
        rst_n        = 1'b0;
        fill         = 1'b0;
        errors       = 0;
        test_err0    = 0;
        tests_run    = 0;
        failed_tests = 0;
        active       = 1'b0;
        done_flag    = 1'b0;
        wp           = 16'h0000;
        test_reset();
        test_moves();
        test_add_flags();
        test_logic();
        test_jump();
        $display("tests run: %0d, failed: %0d, errors: %0d", tests_run, failed_tests, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+include
hw/cpu_pkg.sv
hw/ins_decoder.sv
hw/alu.sv
hw/cpu_control.sv
hw/cpu_top.sv
testbench/tb_mem.sv
testbench/tb_cpu.sv

//--- Makefile
# Verilator simulation of the controller core testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f tb.f --top-module tb_cpu -Mdir obj_dir -o tb_cpu
	./obj_dir/tb_cpu > $(LOG) 2>&1; cat $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
